/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
RTL_TOP   ?= mem_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// widths shared by the memory stage and its data bus

// register and data word width
`define MEM_XLEN 64

// byte address width on the data bus
`define MEM_ADDR_W 64

// one strobe bit per byte lane of a bus word
`define MEM_STRB_W 8

// instruction word width
`define MEM_INST_W 32

`endif

/* source/load_extract.sv */
`timescale 1ns/100ps
`include "mem_settings.svh"

module load_extract (
    input  mem_pkg::mem_op_e     op,
    input  logic [2:0]           addr_low,
    input  logic [`MEM_XLEN-1:0] bus_data,
    output logic [`MEM_XLEN-1:0] load_data
);

    logic [5:0]           bit_shift;
    logic [`MEM_XLEN-1:0] shifted;

    assign bit_shift = {addr_low, 3'b000};

    // the addressed byte ends up in lane 0
    assign shifted = bus_data >> bit_shift;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // width and extension
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (op)
            mem_pkg::OP_LB: begin
                load_data = {{56{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::OP_LH: begin
                load_data = {{48{shifted[15]}}, shifted[15:0]};
            end
            mem_pkg::OP_LW: begin
                load_data = {{32{shifted[31]}}, shifted[31:0]};
            end
            mem_pkg::OP_LBU: begin
                load_data = {56'd0, shifted[7:0]};
            end
            mem_pkg::OP_LHU: begin
                load_data = {48'd0, shifted[15:0]};
            end
            mem_pkg::OP_LWU: begin
                load_data = {32'd0, shifted[31:0]};
            end
            mem_pkg::OP_LD: begin
                load_data = shifted;
            end
            default: begin
                // not a load, the value is never selected
                load_data = '0;
            end
        endcase
    end

endmodule

/* source/mem_access_ctrl.sv */
`timescale 1ns/100ps
`include "mem_settings.svh"

module mem_access_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_pkg::ex_mem_t       ex_mem_state,
    input  mem_pkg::dbus_resp_t    dresp,
    output logic                   req_valid,
    output logic [`MEM_ADDR_W-1:0] req_addr,
    output mem_pkg::mem_size_e     req_size,
    output logic                   is_load,
    output logic                   write,
    output logic                   ok
);

    typedef enum logic {
        REQ,
        WAIT_DATA
    } state_e;

    state_e state;
    state_e state_next;
    logic   is_store;
    logic   mem_access;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // classify the operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        req_size = mem_pkg::SIZE_DOUBLE;
        case (ex_mem_state.op)
            mem_pkg::OP_LB,  mem_pkg::OP_LBU: begin
                is_load  = 1'b1;
                req_size = mem_pkg::SIZE_BYTE;
            end
            mem_pkg::OP_LH,  mem_pkg::OP_LHU: begin
                is_load  = 1'b1;
                req_size = mem_pkg::SIZE_HALF;
            end
            mem_pkg::OP_LW,  mem_pkg::OP_LWU: begin
                is_load  = 1'b1;
                req_size = mem_pkg::SIZE_WORD;
            end
            mem_pkg::OP_LD: is_load = 1'b1;
            mem_pkg::OP_SB: begin
                is_store = 1'b1;
                req_size = mem_pkg::SIZE_BYTE;
            end
            mem_pkg::OP_SH: begin
                is_store = 1'b1;
                req_size = mem_pkg::SIZE_HALF;
            end
            mem_pkg::OP_SW: begin
                is_store = 1'b1;
                req_size = mem_pkg::SIZE_WORD;
            end
            mem_pkg::OP_SD: is_store = 1'b1;
            default: ;
        endcase
    end

    assign mem_access = ex_mem_state.valid && (is_load || is_store);
    assign write      = ex_mem_state.valid && is_store;

    // upstream holds the entry while ok is low, so the address stays put
    assign req_addr = ex_mem_state.alu_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and wait
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_next = state;
        req_valid  = 1'b0;
        ok         = 1'b1;
        case (state)
            REQ: begin
                if (mem_access) begin
                    req_valid = 1'b1;
                    // accept and completion may land in the same cycle
                    ok = dresp.addr_ok && dresp.data_ok;
                    if (dresp.addr_ok && !dresp.data_ok) begin
                        state_next = WAIT_DATA;
                    end
                end
            end
            WAIT_DATA: begin
                ok = dresp.data_ok;
                if (dresp.data_ok) begin
                    state_next = REQ;
                end
            end
            default: state_next = REQ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= REQ;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* source/mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation and access size
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        OP_ALU = 4'd0,
        OP_LB  = 4'd1,
        OP_LH  = 4'd2,
        OP_LW  = 4'd3,
        OP_LD  = 4'd4,
        OP_LBU = 4'd5,
        OP_LHU = 4'd6,
        OP_LWU = 4'd7,
        OP_SB  = 4'd8,
        OP_SH  = 4'd9,
        OP_SW  = 4'd10,
        OP_SD  = 4'd11
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word, bits 11:7 are rd or imm[4:0]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef union packed {
        inst_i_t i_fmt;
        inst_s_t s_fmt;
    } inst_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                     valid;
        logic [`MEM_ADDR_W-1:0]   addr;
        mem_size_e                size;
        logic [`MEM_STRB_W-1:0]   strobe;
        logic [`MEM_XLEN-1:0]     data;
    } dbus_req_t;

    typedef struct packed {
        logic                 addr_ok;
        logic                 data_ok;
        logic [`MEM_XLEN-1:0] data;
    } dbus_resp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline registers and forwarding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        inst_u                  inst;
        logic [`MEM_ADDR_W-1:0] inst_pc;
        logic [`MEM_XLEN-1:0]   alu_result;
        logic [`MEM_XLEN-1:0]   write_mem_data;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        inst_u                  inst;
        logic [`MEM_ADDR_W-1:0] inst_pc;
        logic [`MEM_XLEN-1:0]   value;
        logic                   reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic                 reg_write_enable;
        logic [4:0]           reg_dest_addr;
        logic [`MEM_XLEN-1:0] reg_write_data;
    } reg_writer_t;

endpackage

/* source/mem_result_mux.sv */
`timescale 1ns/100ps
`include "mem_settings.svh"

module mem_result_mux (
    input  mem_pkg::ex_mem_t     ex_mem_state,
    input  logic                 is_load,
    input  logic                 write,
    input  logic [`MEM_XLEN-1:0] load_data,
    output mem_pkg::mem_wb_t     mem_wb_state,
    output mem_pkg::reg_writer_t forward
);

    logic [4:0]           rd;
    logic [`MEM_XLEN-1:0] value;
    logic                 reg_write;

    // stores reuse bits 11:7 as immediate, so rd is only meaningful otherwise
    assign rd = ex_mem_state.inst.i_fmt.rd;

    assign value = is_load ? load_data : ex_mem_state.alu_result;

    // x0 is never written
    assign reg_write = ex_mem_state.valid && !write && (rd != 5'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mem/wb register and forwarding record
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        mem_wb_state.valid     = ex_mem_state.valid;
        mem_wb_state.inst      = ex_mem_state.inst;
        mem_wb_state.inst_pc   = ex_mem_state.inst_pc;
        mem_wb_state.value     = value;
        mem_wb_state.reg_write = reg_write;
    end

    always_comb begin
        forward.reg_write_enable = reg_write;
        forward.reg_dest_addr    = rd;
        forward.reg_write_data   = value;
    end

endmodule

/* source/mem_stage.sv */
`timescale 1ns/100ps
`include "mem_settings.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_pkg::ex_mem_t     ex_mem_state,
    input  mem_pkg::dbus_resp_t  dresp,
    output mem_pkg::dbus_req_t   dreq,
    output mem_pkg::mem_wb_t     mem_wb_state,
    output mem_pkg::reg_writer_t forward,
    output logic                 ok
);

    logic                   req_valid;
    logic [`MEM_ADDR_W-1:0] req_addr;
    mem_pkg::mem_size_e     req_size;
    logic                   is_load;
    logic                   write;
    logic [2:0]             addr_low;
    logic [`MEM_STRB_W-1:0] strobe;
    logic [`MEM_XLEN-1:0]   store_data;
    logic [`MEM_XLEN-1:0]   load_data;

    // byte offset within the doubleword
    assign addr_low = ex_mem_state.alu_result[2:0];

    mem_access_ctrl ctrl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_mem_state (ex_mem_state),
        .dresp        (dresp),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_size     (req_size),
        .is_load      (is_load),
        .write        (write),
        .ok           (ok)
    );

    store_align store0 (
        .op             (ex_mem_state.op),
        .write          (write),
        .addr_low       (addr_low),
        .write_mem_data (ex_mem_state.write_mem_data),
        .strobe         (strobe),
        .data           (store_data)
    );

    load_extract load0 (
        .op        (ex_mem_state.op),
        .addr_low  (addr_low),
        .bus_data  (dresp.data),
        .load_data (load_data)
    );

    mem_result_mux result0 (
        .ex_mem_state (ex_mem_state),
        .is_load      (is_load),
        .write        (write),
        .load_data    (load_data),
        .mem_wb_state (mem_wb_state),
        .forward      (forward)
    );

    assign dreq = '{
        valid:  req_valid,
        addr:   req_addr,
        size:   req_size,
        strobe: strobe,
        data:   store_data
    };

endmodule

/* source/store_align.sv */
`timescale 1ns/100ps
`include "mem_settings.svh"

module store_align (
    input  mem_pkg::mem_op_e       op,
    input  logic                   write,
    input  logic [2:0]             addr_low,
    input  logic [`MEM_XLEN-1:0]   write_mem_data,
    output logic [`MEM_STRB_W-1:0] strobe,
    output logic [`MEM_XLEN-1:0]   data
);

    logic [`MEM_STRB_W-1:0] size_mask;
    logic [5:0]             bit_shift;

    // byte offset turned into a bit offset
    assign bit_shift = {addr_low, 3'b000};

    // low bytes of the store data move up into the addressed lane
    assign data = write_mem_data << bit_shift;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (op)
            mem_pkg::OP_SB: size_mask = 8'h01;
            mem_pkg::OP_SH: size_mask = 8'h03;
            mem_pkg::OP_SW: size_mask = 8'h0f;
            mem_pkg::OP_SD: size_mask = 8'hff;
            default:        size_mask = 8'h00;
        endcase
    end

    always_comb begin
        if (write) begin
            strobe = size_mask << addr_low;
        end else begin
            // reads carry no strobes
            strobe = '0;
        end
    end

endmodule

/* testbench/mem_cases.txt */
# valid op addr wdata inst adly ddly pre_en preset exp_value exp_strobe exp_data exp_fwd
# all hex; op 0 is ALU pass, 1-7 LB LH LW LD LBU LHU LWU, 8-b SB SH SW SD
1 0 deadbeef12345678 0 513 0 0 0 0 deadbeef12345678 0 0 1
1 0 55 0 13 0 0 0 0 55 0 0 0
0 3 1000 0 283 0 0 0 0 0 0 0 0
1 1 1000 0 283 0 1 1 7f8011229c4d85a6 ffffffffffffffa6 0 0 1
1 1 1001 0 283 1 0 1 7f8011229c4d85a6 ffffffffffffff85 0 0 1
1 1 1002 0 283 2 2 1 7f8011229c4d85a6 4d 0 0 1
1 1 1003 0 283 3 1 1 7f8011229c4d85a6 ffffffffffffff9c 0 0 1
1 1 1004 0 283 0 0 1 7f8011229c4d85a6 22 0 0 1
1 1 1005 0 283 1 3 1 7f8011229c4d85a6 11 0 0 1
1 1 1006 0 283 2 0 1 7f8011229c4d85a6 ffffffffffffff80 0 0 1
1 1 1007 0 283 0 2 1 7f8011229c4d85a6 7f 0 0 1
1 5 1000 0 283 1 1 1 7f8011229c4d85a6 a6 0 0 1
1 5 1002 0 283 0 3 1 7f8011229c4d85a6 4d 0 0 1
1 5 1006 0 283 3 0 1 7f8011229c4d85a6 80 0 0 1
1 2 1000 0 283 0 0 1 7f8011229c4d85a6 ffffffffffff85a6 0 0 1
1 2 1002 0 283 2 1 1 7f8011229c4d85a6 ffffffffffff9c4d 0 0 1
1 2 1004 0 283 1 2 1 7f8011229c4d85a6 1122 0 0 1
1 2 1006 0 283 0 1 1 7f8011229c4d85a6 7f80 0 0 1
1 6 1002 0 283 1 0 1 7f8011229c4d85a6 9c4d 0 0 1
1 6 1006 0 283 2 2 1 7f8011229c4d85a6 7f80 0 0 1
1 3 1000 0 283 0 2 1 7f8011229c4d85a6 ffffffff9c4d85a6 0 0 1
1 3 1004 0 283 3 3 1 7f8011229c4d85a6 7f801122 0 0 1
1 7 1000 0 283 1 1 1 7f8011229c4d85a6 9c4d85a6 0 0 1
1 7 1004 0 283 0 0 1 7f8011229c4d85a6 7f801122 0 0 1
1 4 1000 0 3 2 0 1 7f8011229c4d85a6 7f8011229c4d85a6 0 0 0
1 8 2003 a1b2c3d4e5f60718 323 1 1 1 0123456789abcdef 2003 08 d4e5f60718000000 0
1 4 2000 0 283 0 0 0 0 0123456718abcdef 0 0 1
1 9 2006 a1b2c3d4e5f60718 323 2 1 0 0 2006 c0 0718000000000000 0
1 3 2004 0 283 1 0 0 0 7184567 0 0 1
1 a 2000 a1b2c3d4e5f60718 323 0 3 0 0 2000 0f a1b2c3d4e5f60718 0
1 4 2000 0 283 0 0 0 0 07184567e5f60718 0 0 1
1 b 2008 a1b2c3d4e5f60718 323 3 0 1 0 2008 ff a1b2c3d4e5f60718 0
1 4 2008 0 283 0 1 0 0 a1b2c3d4e5f60718 0 0 1

/* testbench/tb_mem_stage.sv */
`timescale 1ns/100ps
`include "mem_settings.svh"

module tb_mem_stage;

    localparam int max_cases = 64;
    localparam int clk_period = 4;

    logic                 clk;
    logic                 rst_n;
    mem_pkg::ex_mem_t     ex_mem_state;
    mem_pkg::dbus_resp_t  dresp;
    mem_pkg::dbus_req_t   dreq;
    mem_pkg::mem_wb_t     mem_wb_state;
    mem_pkg::reg_writer_t forward;
    logic                 ok;

    logic [7:0]  c_valid [max_cases];
    logic [3:0]  c_op [max_cases];
    logic [63:0] c_addr [max_cases];
    logic [63:0] c_wdata [max_cases];
    logic [31:0] c_inst [max_cases];
    logic [7:0]  c_adly [max_cases];
    logic [7:0]  c_ddly [max_cases];
    logic [7:0]  c_pre_en [max_cases];
    logic [63:0] c_preset [max_cases];
    logic [63:0] c_value [max_cases];
    logic [7:0]  c_strobe [max_cases];
    logic [63:0] c_data [max_cases];
    logic [7:0]  c_fwd [max_cases];

    int          num_cases;
    int          pass_count;
    int          fail_count;
    int          errors;
    int          watchdog_cycles;
    bit          cases_loaded;
    int          cur_adly;
    int          cur_ddly;
    int          accept_count;
    logic [31:0] lfsr_state;
    logic [63:0] mem [logic [60:0]];

    mem_stage dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_mem_state (ex_mem_state),
        .dresp        (dresp),
        .dreq         (dreq),
        .mem_wb_state (mem_wb_state),
        .forward      (forward),
        .ok           (ok)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // two bits, so 0 to 3 extra cycles
    function automatic int random_extra();
        int v;
        v = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // byte, half, word or double as encoded on the bus
    function automatic logic [1:0] access_size(input logic [3:0] op);
        case (op)
            4'd1, 4'd5, 4'd8:  return 2'd0;
            4'd2, 4'd6, 4'd9:  return 2'd1;
            4'd3, 4'd7, 4'd10: return 2'd2;
            default:           return 2'd3;
        endcase
    endfunction

    task automatic compare_hex(input int idx, input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        if (got !== exp) begin
            $display("[FAIL] case %0d %s expected %h got %h", idx, name, exp, got);
            errors++;
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        watchdog_cycles = 80;
        fd = $fopen("testbench/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
        end else begin
            while (!$feof(fd) && num_cases < max_cases) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                c_valid[num_cases], c_op[num_cases], c_addr[num_cases],
                                c_wdata[num_cases], c_inst[num_cases], c_adly[num_cases],
                                c_ddly[num_cases], c_pre_en[num_cases], c_preset[num_cases],
                                c_value[num_cases], c_strobe[num_cases], c_data[num_cases],
                                c_fwd[num_cases]);
                    if (n == 13) begin
                        watchdog_cycles += int'(c_adly[num_cases]) + int'(c_ddly[num_cases]) + 12;
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one case
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_case(input int i);
        mem_pkg::dbus_req_t first_req;
        logic [63:0]        pc;
        bit                 is_mem;
        bit                 is_store;
        bit                 accepted;
        bit                 done;
        int                 errs_before;
        errs_before = errors;
        pc = 64'h8000_0000 + 64'(i * 4);
        @(posedge clk);
        #1;
        if (c_pre_en[i] != 0) begin
            mem[c_addr[i][63:3]] = c_preset[i];
        end
        cur_adly = int'(c_adly[i]);
        cur_ddly = int'(c_ddly[i]);
        accept_count = 0;
        ex_mem_state.valid          = c_valid[i][0];
        ex_mem_state.op             = mem_pkg::mem_op_e'(c_op[i]);
        ex_mem_state.inst           = c_inst[i];
        ex_mem_state.inst_pc        = pc;
        ex_mem_state.alu_result     = c_addr[i];
        ex_mem_state.write_mem_data = c_wdata[i];
        #2;
        first_req = dreq;
        is_mem    = c_valid[i][0] && c_op[i] >= 4'd1 && c_op[i] <= 4'd11;
        is_store  = c_op[i] >= 4'd8 && c_op[i] <= 4'd11;
        if (is_mem) begin
            compare_hex(i, "dreq.valid", 64'd1, 64'(dreq.valid));
            compare_hex(i, "dreq.addr", c_addr[i], dreq.addr);
            compare_hex(i, "dreq.size", 64'(access_size(c_op[i])), 64'(dreq.size));
            compare_hex(i, "dreq.strobe", 64'(c_strobe[i]), 64'(dreq.strobe));
            if (is_store) begin
                compare_hex(i, "dreq.data", c_data[i], dreq.data);
            end
        end else begin
            compare_hex(i, "dreq.valid", 64'd0, 64'(dreq.valid));
            compare_hex(i, "ok", 64'd1, 64'(ok));
        end
        done = 1'b0;
        accepted = 1'b0;
        while (!done) begin
            if (is_mem) begin
                if (!accepted && dreq !== first_req) begin
                    $display("case %0d: the request changed before it was accepted", i);
                    errors++;
                end
                if (dresp.addr_ok) begin
                    accepted = 1'b1;
                end
                if (ok !== dresp.data_ok) begin
                    $display("case %0d: ok does not follow the data_ok cycle", i);
                    errors++;
                end
            end
            done = (ok === 1'b1);
            if (!done) begin
                @(posedge clk);
                #3;
            end
        end
        if (c_valid[i][0]) begin
            compare_hex(i, "mem_wb_state.value", c_value[i], mem_wb_state.value);
            compare_hex(i, "forward.reg_write_data", c_value[i], forward.reg_write_data);
            compare_hex(i, "forward.reg_dest_addr", 64'(c_inst[i][11:7]),
                        64'(forward.reg_dest_addr));
        end
        compare_hex(i, "forward.reg_write_enable", 64'(c_fwd[i][0]),
                    64'(forward.reg_write_enable));
        compare_hex(i, "mem_wb_state.reg_write", 64'(c_fwd[i][0]),
                    64'(mem_wb_state.reg_write));
        compare_hex(i, "mem_wb_state.valid", 64'(c_valid[i][0]), 64'(mem_wb_state.valid));
        compare_hex(i, "mem_wb_state.inst", 64'(c_inst[i]), 64'(mem_wb_state.inst));
        compare_hex(i, "mem_wb_state.inst_pc", pc, mem_wb_state.inst_pc);
        if (accept_count != (is_mem ? 1 : 0)) begin
            $display("case %0d: %0d requests accepted on the bus", i, accept_count);
            errors++;
        end
        if (errors == errs_before) begin
            pass_count++;
            $display("case %0d op %h passed", i, c_op[i]);
        end else begin
            fail_count++;
            $display("case %0d op %h failed", i, c_op[i]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus slave, updates outputs 2 ns after the edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        mem_pkg::dbus_req_t held;
        int                 phase;
        int                 a_left;
        int                 d_left;
        logic [63:0]        word;
        dresp = '0;
        phase = 0;
        forever begin
            @(posedge clk);
            #2;
            dresp = '0;
            if (phase == 0 && dreq.valid === 1'b1) begin
                held   = dreq;
                a_left = cur_adly + random_extra();
                d_left = cur_ddly + random_extra();
                phase  = 1;
            end
            if (phase == 1) begin
                if (a_left == 0) begin
                    dresp.addr_ok = 1'b1;
                    accept_count++;
                    phase = 2;
                end else begin
                    a_left--;
                end
            end
            if (phase == 2) begin
                if (d_left == 0) begin
                    word = mem.exists(held.addr[63:3]) ? mem[held.addr[63:3]] : 64'd0;
                    for (int b = 0; b < 8; b++) begin
                        if (held.strobe[b]) begin
                            word[b*8 +: 8] = held.data[b*8 +: 8];
                        end
                    end
                    mem[held.addr[63:3]] = word;
                    dresp.data    = word;
                    dresp.data_ok = 1'b1;
                    phase = 0;
                end else begin
                    d_left--;
                end
            end
        end
    end

    initial begin
        wait (cases_loaded);
        #(watchdog_cycles * clk_period);
        $display("the run timed out while waiting for the DUT");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n        = 1'b0;
        ex_mem_state = '0;
        lfsr_state   = 32'hc4ec_6c19;
        num_cases    = 0;
        pass_count   = 0;
        fail_count   = 0;
        errors       = 0;
        cur_adly     = 0;
        cur_ddly     = 0;
        accept_count = 0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (10) begin
            @(posedge clk);
            #3;
            if (dreq.valid !== 1'b0 || ok !== 1'b1) begin
                $display("during reset the DUT requested the bus or dropped ok");
                errors++;
            end
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        #2;
        if (dreq.valid !== 1'b0 || ok !== 1'b1) begin
            $display("right after reset the DUT requested the bus or dropped ok");
            errors++;
        end
        if (errors != 0) begin
            fail_count++;
            $display("reset checks failed");
        end else begin
            pass_count++;
            $display("reset checks passed");
        end
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        $display("cases passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && num_cases > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
source/mem_pkg.sv
source/mem_access_ctrl.sv
source/store_align.sv
source/load_extract.sv
source/mem_result_mux.sv
source/mem_stage.sv
testbench/tb_mem_stage.sv
